// File: matmul_accel.f
+incdir+src
src/matmul_pkg.sv
src/word_ram.sv
src/mem_arbiter.sv
src/host_port.sv
src/systolic_array.sv
src/matmul_engine.sv
src/matmul_accel.sv
testbench/tb_matmul_accel.sv

// File: testbench/tb_matmul_accel.sv
`timescale 1ns/10ps
`include "matmul_consts.svh"

module tb_matmul_accel;
  import matmul_pkg::*;

  localparam int NUM_TESTS      = 6;
  localparam int TEST_BUDGET_NS = 2000;
  localparam int WAIT_LIMIT     = 64;

  logic      clk_mem;
  logic      reset;
  logic      host_req_valid;
  logic      host_req_ready;
  host_req_s host_req;
  logic      host_rsp_valid;
  logic      host_rsp_ready;
  mem_word_u host_rsp_data;
  logic      start;
  logic      done;

  // Matrices under test and a copy of what the host wrote
  elem_t        a_mat     [`MM_DIM][`MM_DIM];
  elem_t        b_mat     [`MM_DIM][`MM_DIM];
  mem_word_u    mem_model [`MM_DEPTH];
  logic [127:0] exp_q     [$];
  string        name_q    [$];
  int           error_count;
  int           check_count;

  matmul_accel i_dut (
    .clk_mem        (clk_mem),
    .reset          (reset),
    .host_req_valid (host_req_valid),
    .host_req_ready (host_req_ready),
    .host_req       (host_req),
    .host_rsp_valid (host_rsp_valid),
    .host_rsp_ready (host_rsp_ready),
    .host_rsp_data  (host_rsp_data),
    .start          (start),
    .done           (done)
  );

  always #5 clk_mem = ~clk_mem;

  task automatic check_equal(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Signed 4x4 product, one row of C
  function automatic result_row_t ref_c_row(input int i);
    result_row_t row;
    int          sum;
    for (int j = 0; j < `MM_DIM; j++) begin
      sum = 0;
      for (int k = 0; k < `MM_DIM; k++) begin
        sum += int'(a_mat[i][k]) * int'(b_mat[k][j]);
      end
      row[j] = acc_t'(sum);
    end
    return row;
  endfunction

  // Every accepted response is matched against the oldest expected word
  always @(posedge clk_mem) begin
    if (!reset && host_rsp_valid && host_rsp_ready) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("Read response arrived with no read outstanding");
      end else begin
        check_equal(name_q.pop_front(), exp_q.pop_front(), host_rsp_data);
      end
    end
  end

  //////////////////////////////////////////////////
  // Host port tasks
  //////////////////////////////////////////////////

  task automatic issue_request(input logic write, input logic [`MM_ADDR_W-1:0] addr,
                               input mem_word_u wdata, output bit accepted);
    int waited;
    waited = 0;
    @(negedge clk_mem);
    host_req_valid = 1'b1;
    host_req.write = write;
    host_req.addr  = addr;
    host_req.wdata = wdata;
    #1;
    while (!host_req_ready && waited < WAIT_LIMIT) begin
      @(negedge clk_mem);
      #1;
      waited++;
    end
    accepted = host_req_ready;
    if (accepted) begin
      @(posedge clk_mem);
    end else begin
      error_count++;
      $display("Host request to address %0d was never accepted", addr);
    end
    @(negedge clk_mem);
    host_req_valid = 1'b0;
  endtask

  task automatic wait_rsp_valid(output bit seen);
    int waited;
    waited = 0;
    while (!host_rsp_valid && waited < WAIT_LIMIT) begin
      @(negedge clk_mem);
      waited++;
    end
    seen = host_rsp_valid;
    if (!seen) begin
      error_count++;
      $display("Read response never became valid");
    end
  endtask

  task automatic host_write(input logic [`MM_ADDR_W-1:0] addr, input mem_word_u data);
    bit ok;
    issue_request(1'b1, addr, data, ok);
    if (ok) begin
      mem_model[addr] = data;
    end
  endtask

  task automatic host_read(input logic [`MM_ADDR_W-1:0] addr, input logic [127:0] expected,
                           input string name);
    bit ok;
    exp_q.push_back(expected);
    name_q.push_back(name);
    issue_request(1'b0, addr, '0, ok);
    if (ok) begin
      wait_rsp_valid(ok);
    end
    // Response is taken on the rising edge in between
    if (ok) begin
      @(negedge clk_mem);
    end else begin
      exp_q.delete();
      name_q.delete();
    end
  endtask

  //////////////////////////////////////////////////
  // Engine tasks
  //////////////////////////////////////////////////

  task automatic randomize_matrices();
    for (int i = 0; i < `MM_DIM; i++) begin
      for (int k = 0; k < `MM_DIM; k++) begin
        a_mat[i][k] = elem_t'($urandom());
        b_mat[i][k] = elem_t'($urandom());
      end
    end
  endtask

  // A rows then B rows, elements in the low operand lanes
  task automatic load_matrices();
    mem_word_u w;
    for (int i = 0; i < `MM_DIM; i++) begin
      w = '0;
      for (int k = 0; k < `MM_DIM; k++) begin
        w.operand.elem[k] = a_mat[i][k];
      end
      host_write(`MM_ADDR_W'(`MM_A_BASE + i), w);
    end
    for (int k = 0; k < `MM_DIM; k++) begin
      w = '0;
      for (int j = 0; j < `MM_DIM; j++) begin
        w.operand.elem[j] = b_mat[k][j];
      end
      host_write(`MM_ADDR_W'(`MM_B_BASE + k), w);
    end
  endtask

  task automatic run_engine();
    int waited;
    waited = 0;
    @(negedge clk_mem);
    start = 1'b1;
    @(negedge clk_mem);
    start = 1'b0;
    while (!done && waited < WAIT_LIMIT) begin
      @(negedge clk_mem);
      waited++;
    end
    if (!done) begin
      error_count++;
      $display("Engine never raised done after start");
    end
  endtask

  task automatic check_result_rows(input string name);
    for (int i = 0; i < `MM_DIM; i++) begin
      host_read(`MM_ADDR_W'(`MM_C_BASE + i), ref_c_row(i), $sformatf("%s C row %0d", name, i));
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    $display("Test %-16s %s", name, (error_count == errors_before) ? "pass" : "fail");
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int          errs;
    bit          ok;
    mem_word_u   w;
    mem_word_u   held;
    result_row_t ext_row;
    void'($urandom(32'hbbbb_f0d6));
    clk_mem        = 1'b0;
    reset          = 1'b1;
    host_req_valid = 1'b0;
    host_req       = '0;
    host_rsp_ready = 1'b1;
    start          = 1'b0;
    error_count    = 0;
    check_count    = 0;
    repeat (2) @(negedge clk_mem);
    reset = 1'b0;

    errs = error_count;
    @(negedge clk_mem);
    check_equal("after_reset done", 0, done);
    check_equal("after_reset rsp_valid", 0, host_rsp_valid);
    finish_test("after_reset", errs);

    errs = error_count;
    for (int a = 0; a < 8; a++) begin
      w = {$urandom(), $urandom(), $urandom(), $urandom()};
      host_write(`MM_ADDR_W'(a), w);
    end
    for (int a = 0; a < 8; a++) begin
      host_read(`MM_ADDR_W'(a), mem_model[a], $sformatf("round_trip addr %0d", a));
    end
    finish_test("round_trip", errs);

    errs = error_count;
    randomize_matrices();
    load_matrices();
    run_engine();
    check_result_rows("random_product");
    finish_test("random_product", errs);

    // Every product is 16384, four per element
    errs = error_count;
    for (int i = 0; i < `MM_DIM; i++) begin
      for (int k = 0; k < `MM_DIM; k++) begin
        a_mat[i][k] = elem_t'(-128);
        b_mat[i][k] = elem_t'(-128);
      end
      ext_row[i] = acc_t'(4 * 16384);
    end
    load_matrices();
    run_engine();
    for (int i = 0; i < `MM_DIM; i++) begin
      host_read(`MM_ADDR_W'(`MM_C_BASE + i), ext_row, $sformatf("extreme C row %0d", i));
    end
    finish_test("extreme", errs);

    errs = error_count;
    w = {$urandom(), $urandom(), $urandom(), $urandom()};
    host_write(`MM_ADDR_W'(6), w);
    host_rsp_ready = 1'b0;
    exp_q.push_back(mem_model[6]);
    name_q.push_back("backpressure read");
    issue_request(1'b0, `MM_ADDR_W'(6), '0, ok);
    if (ok) begin
      wait_rsp_valid(ok);
    end
    if (ok) begin
      held = host_rsp_data;
      // A competing write that must not be accepted
      host_req_valid = 1'b1;
      host_req.write = 1'b1;
      host_req.addr  = `MM_ADDR_W'(6);
      host_req.wdata = ~held;
      repeat (6) begin
        #1;
        check_equal("backpressure req_ready", 0, host_req_ready);
        check_equal("backpressure rsp_valid", 1, host_rsp_valid);
        check_equal("backpressure rsp_data", held, host_rsp_data);
        @(negedge clk_mem);
      end
      host_req_valid = 1'b0;
      host_rsp_ready = 1'b1;
      @(negedge clk_mem);
    end else begin
      exp_q.delete();
      name_q.delete();
      host_rsp_ready = 1'b1;
    end
    host_read(`MM_ADDR_W'(6), mem_model[6], "backpressure reread");
    finish_test("backpressure", errs);

    errs = error_count;
    randomize_matrices();
    load_matrices();
    fork
      run_engine();
      begin
        @(negedge clk_mem);
        host_read(`MM_ADDR_W'(`MM_B_BASE + 1), mem_model[`MM_B_BASE + 1],
                  "compute_overlap host read");
      end
    join
    check_result_rows("compute_overlap");
    finish_test("compute_overlap", errs);

    $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NUM_TESTS * TEST_BUDGET_NS);
    $display("Watchdog expired after %0d ns with tests still running",
             NUM_TESTS * TEST_BUDGET_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: src/matmul_accel.sv
`timescale 1ns/10ps

module matmul_accel (
  input  logic                  clk_mem,
  input  logic                  reset,
  input  logic                  host_req_valid,
  output logic                  host_req_ready,
  input  matmul_pkg::host_req_s host_req,
  output logic                  host_rsp_valid,
  input  logic                  host_rsp_ready,
  output matmul_pkg::mem_word_u host_rsp_data,
  input  logic                  start,
  output logic                  done
);

  // Host path into the arbiter
  logic                  host_mreq_valid;
  matmul_pkg::mem_req_s  host_mreq;
  logic                  host_grant;
  logic                  host_rvalid;

  // Engine path into the arbiter
  logic                  eng_mreq_valid;
  matmul_pkg::mem_req_s  eng_mreq;
  logic                  eng_grant;
  logic                  eng_rvalid;

  // Read data is shared, the strobes tell the owners apart
  matmul_pkg::mem_word_u rdata;

  host_port u_host_port (
    .clk_mem        (clk_mem),
    .reset          (reset),
    .host_req_valid (host_req_valid),
    .host_req_ready (host_req_ready),
    .host_req       (host_req),
    .host_rsp_valid (host_rsp_valid),
    .host_rsp_ready (host_rsp_ready),
    .host_rsp_data  (host_rsp_data),
    .mreq_valid     (host_mreq_valid),
    .mreq           (host_mreq),
    .grant          (host_grant),
    .rvalid         (host_rvalid),
    .rdata          (rdata)
  );

  matmul_engine u_matmul_engine (
    .clk_mem    (clk_mem),
    .reset      (reset),
    .start      (start),
    .done       (done),
    .mreq_valid (eng_mreq_valid),
    .mreq       (eng_mreq),
    .grant      (eng_grant),
    .rvalid     (eng_rvalid),
    .rdata      (rdata)
  );

  mem_arbiter u_mem_arbiter (
    .clk_mem         (clk_mem),
    .reset           (reset),
    .host_mreq_valid (host_mreq_valid),
    .host_mreq       (host_mreq),
    .host_grant      (host_grant),
    .host_rvalid     (host_rvalid),
    .eng_mreq_valid  (eng_mreq_valid),
    .eng_mreq        (eng_mreq),
    .eng_grant       (eng_grant),
    .eng_rvalid      (eng_rvalid),
    .rdata           (rdata)
  );

endmodule

// File: src/matmul_engine.sv
`timescale 1ns/10ps
`include "matmul_consts.svh"

module matmul_engine (
  input  logic                  clk_mem,
  input  logic                  reset,
  input  logic                  start,
  output logic                  done,
  output logic                  mreq_valid,
  output matmul_pkg::mem_req_s  mreq,
  input  logic                  grant,
  input  logic                  rvalid,
  input  matmul_pkg::mem_word_u rdata
);
  import matmul_pkg::*;

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_LOAD    = 2'd1;
  localparam logic [1:0] ST_COMPUTE = 2'd2;
  localparam logic [1:0] ST_WRITE   = 2'd3;

  localparam int LOAD_WORDS    = 2 * `MM_DIM;
  // Operand steps plus skew drain
  localparam int COMPUTE_STEPS = 3 * `MM_DIM - 2;
  localparam int CNT_W         = $clog2(COMPUTE_STEPS);
  localparam int LANE_W        = $clog2(`MM_DIM);

  logic [1:0]       state;
  logic [CNT_W-1:0] cnt;
  logic [LANE_W:0]  cap_cnt;
  logic             clear;
  logic             step;
  operand_row_s     a_rows [`MM_DIM];
  operand_row_s     b_rows [`MM_DIM];
  elem_t            a_col  [`MM_DIM];
  elem_t            b_row  [`MM_DIM];
  result_row_t      c_rows [`MM_DIM];

  assign clear = start & (state == ST_IDLE);
  assign step  = (state == ST_COMPUTE);

  //////////////////////////////////////////////////
  // Load, compute, write-back FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      state <= ST_IDLE;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_LOAD;
            cnt   <= '0;
          end
        end
        ST_LOAD: begin
          if (grant) begin
            if (cnt == CNT_W'(LOAD_WORDS - 1)) begin
              state <= ST_COMPUTE;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        ST_COMPUTE: begin
          // Overlaps the last reads, which are needed only by later steps
          if (cnt == CNT_W'(COMPUTE_STEPS - 1)) begin
            state <= ST_WRITE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          if (grant) begin
            if (cnt == CNT_W'(`MM_DIM - 1)) begin
              state <= ST_IDLE;
              cnt   <= '0;
              done  <= 1'b1;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // Read data arrives in issue order, A rows then B rows
  always_ff @(posedge clk_mem) begin
    if (reset || clear) begin
      cap_cnt <= '0;
    end else if (rvalid) begin
      cap_cnt <= cap_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_mem) begin
    if (rvalid) begin
      if (!cap_cnt[LANE_W]) begin
        a_rows[cap_cnt[LANE_W-1:0]] <= rdata.operand;
      end else begin
        b_rows[cap_cnt[LANE_W-1:0]] <= rdata.operand;
      end
    end
  end

  //////////////////////////////////////////////////
  // Skewed feed, lane n lags by n steps
  //////////////////////////////////////////////////

  always_comb begin
    int k;
    for (int n = 0; n < `MM_DIM; n++) begin
      k = int'(cnt) - n;
      a_col[n] = (step && k >= 0 && k < `MM_DIM) ? a_rows[n].elem[k] : '0;
      b_row[n] = (step && k >= 0 && k < `MM_DIM) ? b_rows[k].elem[n] : '0;
    end
  end

  // Memory requests
  always_comb begin
    mreq       = '0;
    mreq_valid = 1'b0;
    if (state == ST_LOAD) begin
      mreq_valid = 1'b1;
      if (int'(cnt) < `MM_DIM) begin
        mreq.addr = `MM_ADDR_W'(`MM_A_BASE + int'(cnt));
      end else begin
        mreq.addr = `MM_ADDR_W'(`MM_B_BASE + int'(cnt) - `MM_DIM);
      end
    end else if (state == ST_WRITE) begin
      mreq_valid         = 1'b1;
      mreq.write         = 1'b1;
      mreq.addr          = `MM_ADDR_W'(`MM_C_BASE + int'(cnt));
      mreq.wdata.result  = c_rows[cnt[LANE_W-1:0]];
    end
  end

  systolic_array u_systolic_array (
    .clk_mem (clk_mem),
    .reset   (reset),
    .clear   (clear),
    .step    (step),
    .a_col   (a_col),
    .b_row   (b_row),
    .c_rows  (c_rows)
  );

  a_done_pulse : assert property (
    @(posedge clk_mem) disable iff (reset) done |=> !done
  ) else $error("matmul_engine: done held for more than one cycle");

endmodule

// File: src/systolic_array.sv
`timescale 1ns/10ps
`include "matmul_consts.svh"

module systolic_array (
  input  logic                    clk_mem,
  input  logic                    reset,
  input  logic                    clear,
  input  logic                    step,
  input  matmul_pkg::elem_t       a_col [`MM_DIM],
  input  matmul_pkg::elem_t       b_row [`MM_DIM],
  output matmul_pkg::result_row_t c_rows [`MM_DIM]
);
  import matmul_pkg::*;

  // Registered operands leaving each cell
  elem_t a_fwd    [`MM_DIM][`MM_DIM];
  elem_t b_fwd    [`MM_DIM][`MM_DIM];
  acc_t  acc_grid [`MM_DIM][`MM_DIM];

  //////////////////////////////////////////////////
  // Cell grid, A moves right and B moves down
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `MM_DIM; i++) begin : g_row
    for (genvar j = 0; j < `MM_DIM; j++) begin : g_col
      elem_t a_in;
      elem_t b_in;
      elem_t a_q;
      elem_t b_q;
      acc_t  acc_q;

      // Left column takes A from the feeder
      if (j == 0) begin : g_a_edge
        assign a_in = a_col[i];
      end else begin : g_a_link
        assign a_in = a_fwd[i][j-1];
      end

      // Top row takes B from the feeder
      if (i == 0) begin : g_b_edge
        assign b_in = b_row[j];
      end else begin : g_b_link
        assign b_in = b_fwd[i-1][j];
      end

      always_ff @(posedge clk_mem) begin
        if (reset || clear) begin
          a_q   <= '0;
          b_q   <= '0;
          acc_q <= '0;
        end else if (step) begin
          a_q   <= a_in;
          b_q   <= b_in;
          // Signed product widened to the accumulator
          acc_q <= acc_q + a_in * b_in;
        end
      end

      assign a_fwd[i][j]    = a_q;
      assign b_fwd[i][j]    = b_q;
      assign acc_grid[i][j] = acc_q;
    end
  end

  //////////////////////////////////////////////////
  // Output stationary results
  //////////////////////////////////////////////////

  always_comb begin
    for (int r = 0; r < `MM_DIM; r++) begin
      for (int c = 0; c < `MM_DIM; c++) begin
        c_rows[r][c] = acc_grid[r][c];
      end
    end
  end

endmodule

// File: src/host_port.sv
`timescale 1ns/10ps
`include "matmul_consts.svh"

module host_port (
  input  logic                  clk_mem,
  input  logic                  reset,
  input  logic                  host_req_valid,
  output logic                  host_req_ready,
  input  matmul_pkg::host_req_s host_req,
  output logic                  host_rsp_valid,
  input  logic                  host_rsp_ready,
  output matmul_pkg::mem_word_u host_rsp_data,
  output logic                  mreq_valid,
  output matmul_pkg::mem_req_s  mreq,
  input  logic                  grant,
  input  logic                  rvalid,
  input  matmul_pkg::mem_word_u rdata
);
  import matmul_pkg::*;

  logic      rd_pending;
  logic      rsp_valid_q;
  mem_word_u rsp_data_q;
  logic      busy;
  logic      req_fire;

  // One read in flight or one response waiting blocks new requests
  assign busy = rd_pending | rsp_valid_q;

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  assign mreq_valid = host_req_valid & ~busy;
  assign mreq       = '{write: host_req.write, addr: host_req.addr, wdata: host_req.wdata};

  // Accepted in the cycle the arbiter grants it
  assign host_req_ready = grant & ~busy;
  assign req_fire       = host_req_valid & host_req_ready;

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      rd_pending  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      // Data comes back exactly one cycle after the grant
      rd_pending <= req_fire & ~host_req.write;
      if (rvalid) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_valid_q && host_rsp_ready) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // Held until the host takes it
  always_ff @(posedge clk_mem) begin
    if (rvalid) begin
      rsp_data_q <= rdata;
    end
  end

  assign host_rsp_valid = rsp_valid_q;
  assign host_rsp_data  = rsp_data_q;

endmodule

// File: src/mem_arbiter.sv
`timescale 1ns/10ps
`include "matmul_consts.svh"

module mem_arbiter (
  input  logic                  clk_mem,
  input  logic                  reset,
  input  logic                  host_mreq_valid,
  input  matmul_pkg::mem_req_s  host_mreq,
  output logic                  host_grant,
  output logic                  host_rvalid,
  input  logic                  eng_mreq_valid,
  input  matmul_pkg::mem_req_s  eng_mreq,
  output logic                  eng_grant,
  output logic                  eng_rvalid,
  output matmul_pkg::mem_word_u rdata
);
  import matmul_pkg::*;

  mem_req_s              sel_req;
  logic [`MM_ADDR_W-1:0] ram_addr;
  logic                  ram_we;

  //////////////////////////////////////////////////
  // Fixed priority with the engine first
  //////////////////////////////////////////////////

  assign eng_grant  = eng_mreq_valid;
  assign host_grant = host_mreq_valid & ~eng_mreq_valid;

  assign sel_req  = eng_mreq_valid ? eng_mreq : host_mreq;
  assign ram_addr = sel_req.addr;
  assign ram_we   = (eng_grant | host_grant) & sel_req.write;

  // Tag each granted read so the data strobe goes back to its owner
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      host_rvalid <= 1'b0;
      eng_rvalid  <= 1'b0;
    end else begin
      host_rvalid <= host_grant & ~host_mreq.write;
      eng_rvalid  <= eng_grant & ~eng_mreq.write;
    end
  end

  word_ram u_word_ram (
    .clk_mem (clk_mem),
    .addr    (ram_addr),
    .wdata   (sel_req.wdata),
    .we      (ram_we),
    .rdata   (rdata)
  );

  // A waiting host request holds until its grant
  a_host_req_held : assert property (
    @(posedge clk_mem) disable iff (reset)
      host_mreq_valid && !host_grant |=> host_mreq_valid && $stable(host_mreq)
  ) else $error("mem_arbiter: host request changed before its grant");

endmodule

// File: src/word_ram.sv
`timescale 1ns/10ps
`include "matmul_consts.svh"

module word_ram (
  input  logic                  clk_mem,
  input  logic [`MM_ADDR_W-1:0] addr,
  input  matmul_pkg::mem_word_u wdata,
  input  logic                  we,
  output matmul_pkg::mem_word_u rdata
);
  import matmul_pkg::*;

  // Operand rows and result rows share this store
  mem_word_u mem [`MM_DEPTH];

  always_ff @(posedge clk_mem) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    // Read returns the old word on a same-address write
    rdata <= mem[addr];
  end

  // Writes must land inside the array at a known address
  a_write_in_range : assert property (
    @(posedge clk_mem) we |-> !$isunknown(addr) && (int'(addr) < `MM_DEPTH)
  ) else $error("word_ram: write to unknown or out-of-range address %0d", addr);

endmodule

// File: src/matmul_pkg.sv
`include "matmul_consts.svh"

package matmul_pkg;

  // Signed operand element
  typedef logic signed [`MM_ELEM_W-1:0] elem_t;

  // Signed accumulator, also the result element
  typedef logic signed [`MM_ACC_W-1:0] acc_t;

  // Operand row sits in the low bits of a memory word
  typedef struct packed {
    logic [`MM_DIM*(`MM_ACC_W-`MM_ELEM_W)-1:0] pad;
    elem_t [`MM_DIM-1:0]                       elem;
  } operand_row_s;

  // Full-width result row
  typedef acc_t [`MM_DIM-1:0] result_row_t;

  // One memory word, read as operands or as results
  typedef union packed {
    operand_row_s operand;
    result_row_t  result;
  } mem_word_u;

  // Single access on the memory port
  typedef struct packed {
    logic                  write;
    logic [`MM_ADDR_W-1:0] addr;
    mem_word_u             wdata;
  } mem_req_s;

  // Host-side request
  typedef struct packed {
    logic                  write;
    logic [`MM_ADDR_W-1:0] addr;
    mem_word_u             wdata;
  } host_req_s;

endpackage

// File: src/matmul_consts.svh
`ifndef MATMUL_CONSTS_SVH
`define MATMUL_CONSTS_SVH

//////////////////////////////////////////////////
// Array geometry
//////////////////////////////////////////////////

`define MM_DIM     4
`define MM_ELEM_W  8
`define MM_ACC_W   32

//////////////////////////////////////////////////
// Shared word memory and its map
//////////////////////////////////////////////////

`define MM_ADDR_W  4
`define MM_DEPTH   16

// One matrix row per word
`define MM_A_BASE  0
`define MM_B_BASE  4
`define MM_C_BASE  8

`endif
